//--- controlUnit.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/opcodeDecoder.sv
rtl/stepSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnit.sv
verif/controlUnit_assert.sv
verif/controlUnitTb.sv

//--- rtl/controlUnit.sv
module controlUnit #(
	parameter int irWidth = isaPkg::irWidth
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [irWidth-1:0]    irReg,
	input  logic                  conff,
	output ctrlPkg::controlWord_t ctrl,
	output logic                  halted
);

	ctrlPkg::decoded_t decoded;
	ctrlPkg::decoded_t held;
	ctrlPkg::step_t step;

	opcodeDecoder #(
		.irWidth(irWidth)
	) decoder0 (
		.irReg(irReg),
		.decoded(decoded)
	);

	stepSequencer sequencer0 (
		.clock(clock),
		.reset(reset),
		.decoded(decoded),
		.step(step),
		.held(held),
		.halted(halted)
	);

	// Word follows the registered step, valid for the whole cycle
	controlWordGen wordGen0 (
		.step(step),
		.held(held),
		.conff(conff),
		.ctrl(ctrl)
	);

endmodule

//--- rtl/controlWordGen.sv
module controlWordGen (
	input  ctrlPkg::step_t        step,
	input  ctrlPkg::decoded_t     held,
	input  logic                  conff,
	output ctrlPkg::controlWord_t ctrl
);

	always_comb begin
		ctrl = '0;

		case (step)
			ctrlPkg::stReset: ctrl.clear = 1'b1;

			// ----------------------------------------------------------------
			// Fetch
			// ----------------------------------------------------------------
			ctrlPkg::stT0: begin
				ctrl.pcOut = 1'b1;
				ctrl.marIn = 1'b1;
				ctrl.incPc = 1'b1;
				ctrl.zLowIn = 1'b1;
			end
			ctrlPkg::stT1: begin
				ctrl.zLowOut = 1'b1;
				ctrl.pcIn = 1'b1;
				ctrl.mdRead = 1'b1;
				ctrl.mdrIn = 1'b1;
			end
			ctrlPkg::stT2: begin
				ctrl.mdrOut = 1'b1;
				ctrl.irIn = 1'b1;
			end

			// ----------------------------------------------------------------
			// Execute
			// ----------------------------------------------------------------
			ctrlPkg::stX1: begin
				case (held.cls)
					// Base register into Y, R0 reads as zero through BA
					isaPkg::clsLoad, isaPkg::clsLoadImm, isaPkg::clsStore: begin
						ctrl.grb = 1'b1;
						ctrl.baOut = 1'b1;
						ctrl.yIn = 1'b1;
					end
					isaPkg::clsAluReg, isaPkg::clsAluImm: begin
						ctrl.grb = 1'b1;
						ctrl.rOut = 1'b1;
						ctrl.yIn = 1'b1;
					end
					// Condition register evaluates Ra
					isaPkg::clsBranch: begin
						ctrl.gra = 1'b1;
						ctrl.rOut = 1'b1;
						ctrl.conIn = 1'b1;
					end
					isaPkg::clsJumpReg: begin
						ctrl.gra = 1'b1;
						ctrl.rOut = 1'b1;
						ctrl.pcIn = 1'b1;
					end
					default: ;
				endcase
			end

			ctrlPkg::stX2: begin
				case (held.cls)
					isaPkg::clsLoad, isaPkg::clsLoadImm, isaPkg::clsStore,
					isaPkg::clsAluImm: begin
						ctrl.cSignOut = 1'b1;
						ctrl.aluOp = held.aluOp;
						ctrl.zLowIn = 1'b1;
					end
					isaPkg::clsAluReg: begin
						ctrl.grc = 1'b1;
						ctrl.rOut = 1'b1;
						ctrl.aluOp = held.aluOp;
						ctrl.zLowIn = 1'b1;
					end
					isaPkg::clsBranch: begin
						ctrl.pcOut = 1'b1;
						ctrl.yIn = 1'b1;
					end
					default: ;
				endcase
			end

			ctrlPkg::stX3: begin
				case (held.cls)
					// Effective address to MAR
					isaPkg::clsLoad, isaPkg::clsStore: begin
						ctrl.zLowOut = 1'b1;
						ctrl.marIn = 1'b1;
					end
					// Result write-back to Ra
					isaPkg::clsLoadImm, isaPkg::clsAluReg, isaPkg::clsAluImm: begin
						ctrl.zLowOut = 1'b1;
						ctrl.gra = 1'b1;
						ctrl.rIn = 1'b1;
					end
					// Branch target is PC plus offset
					isaPkg::clsBranch: begin
						ctrl.cSignOut = 1'b1;
						ctrl.aluOp = held.aluOp;
						ctrl.zLowIn = 1'b1;
					end
					default: ;
				endcase
			end

			ctrlPkg::stX4: begin
				case (held.cls)
					isaPkg::clsLoad: begin
						ctrl.mdRead = 1'b1;
						ctrl.mdrIn = 1'b1;
					end
					isaPkg::clsStore: begin
						ctrl.gra = 1'b1;
						ctrl.baOut = 1'b1;
						ctrl.write = 1'b1;
					end
					// PC only takes the target when the condition held
					isaPkg::clsBranch: begin
						ctrl.zLowOut = 1'b1;
						ctrl.pcIn = conff;
					end
					default: ;
				endcase
			end

			ctrlPkg::stX5: begin
				if (held.cls == isaPkg::clsLoad) begin
					ctrl.mdrOut = 1'b1;
					ctrl.gra = 1'b1;
					ctrl.rIn = 1'b1;
				end
			end

			// Halted and anything unexpected drive nothing
			default: ;
		endcase
	end

endmodule

//--- rtl/ctrlPkg.sv
package ctrlPkg;

	// Sequencer states, one per clock
	typedef enum logic [3:0] {
		stReset,
		stT0,
		stT1,
		stT2,
		stX1,
		stX2,
		stX3,
		stX4,
		stX5,
		stHalted
	} step_t;

	// Operation presented to the ALU
	typedef enum logic [3:0] {
		aluNone,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShr,
		aluShra,
		aluShl,
		aluRor,
		aluRol,
		aluBranch
	} aluOp_t;

	typedef struct packed {
		isaPkg::instrClass_t cls;
		aluOp_t aluOp;
	} decoded_t;

	// ------------------------------------------------------------------------
	// Control word, one bundle per step
	// ------------------------------------------------------------------------
	typedef struct packed {
		// Bus sources
		logic pcOut;
		logic mdrOut;
		logic zLowOut;
		logic rOut;
		logic baOut;
		logic cSignOut;
		// Register file selects
		logic gra;
		logic grb;
		logic grc;
		// Register loads
		logic rIn;
		logic mdrIn;
		logic marIn;
		logic yIn;
		logic irIn;
		logic pcIn;
		logic conIn;
		logic zLowIn;
		// Memory and PC
		logic incPc;
		logic mdRead;
		logic write;
		logic clear;
		aluOp_t aluOp;
	} controlWord_t;

	// Execution steps per class, in instrClass_t order
	// Halt never returns to T0 so its entry is unused
	localparam logic [2:0] execSteps [9] = '{
		3'd5, 3'd3, 3'd4, 3'd3, 3'd3, 3'd4, 3'd1, 3'd1, 3'd0
	};

endpackage

//--- rtl/isaPkg.sv
package isaPkg;

	// ------------------------------------------------------------------------
	// Instruction register layout
	// ------------------------------------------------------------------------
	localparam int irWidth = 32;

	// Opcode sits in the top five bits
	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 27;
	localparam int opcodeWidth = opcodeMsb - opcodeLsb + 1;

	// ------------------------------------------------------------------------
	// Opcodes kept in this build
	// ------------------------------------------------------------------------
	typedef enum logic [opcodeWidth-1:0] {
		opLd   = 5'd0,
		opLdi  = 5'd1,
		opSt   = 5'd2,
		opAdd  = 5'd3,
		opSub  = 5'd4,
		opShr  = 5'd5,
		opShra = 5'd6,
		opShl  = 5'd7,
		opRor  = 5'd8,
		opRol  = 5'd9,
		opAnd  = 5'd10,
		opOr   = 5'd11,
		opAddi = 5'd12,
		opAndi = 5'd13,
		opOri  = 5'd14,
		// Gap left by the dropped mul, div, neg and not
		opBr   = 5'd19,
		opJr   = 5'd20,
		opNop  = 5'd26,
		opHalt = 5'd27
	} opcode_t;

	// Instructions that share an execution sequence
	typedef enum logic [3:0] {
		clsLoad,
		clsLoadImm,
		clsStore,
		clsAluReg,
		clsAluImm,
		clsBranch,
		clsJumpReg,
		clsNop,
		clsHalt
	} instrClass_t;

endpackage

//--- rtl/opcodeDecoder.sv
module opcodeDecoder #(
	parameter int irWidth = isaPkg::irWidth
) (
	input  logic [irWidth-1:0] irReg,
	output ctrlPkg::decoded_t  decoded
);

	isaPkg::opcode_t opcode;

	assign opcode = isaPkg::opcode_t'(irReg[isaPkg::opcodeMsb:isaPkg::opcodeLsb]);

	always_comb begin
		// Unlisted opcodes fall through as nop
		decoded.cls = isaPkg::clsNop;
		decoded.aluOp = ctrlPkg::aluNone;

		case (opcode)
			// Memory ops compute base plus offset
			isaPkg::opLd: begin
				decoded.cls = isaPkg::clsLoad;
				decoded.aluOp = ctrlPkg::aluAdd;
			end
			isaPkg::opLdi: begin
				decoded.cls = isaPkg::clsLoadImm;
				decoded.aluOp = ctrlPkg::aluAdd;
			end
			isaPkg::opSt: begin
				decoded.cls = isaPkg::clsStore;
				decoded.aluOp = ctrlPkg::aluAdd;
			end

			// Register-register ALU
			isaPkg::opAdd: begin
				decoded.cls = isaPkg::clsAluReg;
				decoded.aluOp = ctrlPkg::aluAdd;
			end
			isaPkg::opSub: begin
				decoded.cls = isaPkg::clsAluReg;
				decoded.aluOp = ctrlPkg::aluSub;
			end
			isaPkg::opAnd: begin
				decoded.cls = isaPkg::clsAluReg;
				decoded.aluOp = ctrlPkg::aluAnd;
			end
			isaPkg::opOr: begin
				decoded.cls = isaPkg::clsAluReg;
				decoded.aluOp = ctrlPkg::aluOr;
			end
			isaPkg::opShr: begin
				decoded.cls = isaPkg::clsAluReg;
				decoded.aluOp = ctrlPkg::aluShr;
			end
			isaPkg::opShra: begin
				decoded.cls = isaPkg::clsAluReg;
				decoded.aluOp = ctrlPkg::aluShra;
			end
			isaPkg::opShl: begin
				decoded.cls = isaPkg::clsAluReg;
				decoded.aluOp = ctrlPkg::aluShl;
			end
			isaPkg::opRor: begin
				decoded.cls = isaPkg::clsAluReg;
				decoded.aluOp = ctrlPkg::aluRor;
			end
			isaPkg::opRol: begin
				decoded.cls = isaPkg::clsAluReg;
				decoded.aluOp = ctrlPkg::aluRol;
			end

			// Immediate forms take C from the sign-extended field
			isaPkg::opAddi: begin
				decoded.cls = isaPkg::clsAluImm;
				decoded.aluOp = ctrlPkg::aluAdd;
			end
			isaPkg::opAndi: begin
				decoded.cls = isaPkg::clsAluImm;
				decoded.aluOp = ctrlPkg::aluAnd;
			end
			isaPkg::opOri: begin
				decoded.cls = isaPkg::clsAluImm;
				decoded.aluOp = ctrlPkg::aluOr;
			end

			isaPkg::opBr: begin
				decoded.cls = isaPkg::clsBranch;
				decoded.aluOp = ctrlPkg::aluBranch;
			end
			isaPkg::opJr:   decoded.cls = isaPkg::clsJumpReg;
			isaPkg::opHalt: decoded.cls = isaPkg::clsHalt;
			default: ;
		endcase
	end

endmodule

//--- rtl/stepSequencer.sv
module stepSequencer (
	input  logic              clock,
	input  logic              reset,
	input  ctrlPkg::decoded_t decoded,
	output ctrlPkg::step_t    step,
	output ctrlPkg::decoded_t held,
	output logic              halted
);

	ctrlPkg::step_t nextStep;
	logic [2:0] stepNum;
	logic lastStep;

	// ------------------------------------------------------------------------
	// Execution step position
	// ------------------------------------------------------------------------
	always_comb begin
		case (step)
			ctrlPkg::stX1: stepNum = 3'd1;
			ctrlPkg::stX2: stepNum = 3'd2;
			ctrlPkg::stX3: stepNum = 3'd3;
			ctrlPkg::stX4: stepNum = 3'd4;
			ctrlPkg::stX5: stepNum = 3'd5;
			default:       stepNum = 3'd0;
		endcase
	end

	// Done when the count for the held class is reached
	assign lastStep = (stepNum == ctrlPkg::execSteps[held.cls]);

	// ------------------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------------------
	always_comb begin
		nextStep = step;
		case (step)
			ctrlPkg::stReset: nextStep = ctrlPkg::stT0;
			ctrlPkg::stT0:    nextStep = ctrlPkg::stT1;
			ctrlPkg::stT1:    nextStep = ctrlPkg::stT2;
			ctrlPkg::stT2: begin
				if (decoded.cls == isaPkg::clsHalt)
					nextStep = ctrlPkg::stHalted;
				else
					nextStep = ctrlPkg::stX1;
			end
			ctrlPkg::stX1: nextStep = lastStep ? ctrlPkg::stT0 : ctrlPkg::stX2;
			ctrlPkg::stX2: nextStep = lastStep ? ctrlPkg::stT0 : ctrlPkg::stX3;
			ctrlPkg::stX3: nextStep = lastStep ? ctrlPkg::stT0 : ctrlPkg::stX4;
			ctrlPkg::stX4: nextStep = lastStep ? ctrlPkg::stT0 : ctrlPkg::stX5;
			// Longest sequence is five steps
			ctrlPkg::stX5: nextStep = ctrlPkg::stT0;
			// Parked until reset
			ctrlPkg::stHalted: nextStep = ctrlPkg::stHalted;
			default: nextStep = ctrlPkg::stReset;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			step <= ctrlPkg::stReset;
			held.cls <= isaPkg::clsNop;
			held.aluOp <= ctrlPkg::aluNone;
		end else begin
			step <= nextStep;
			// IR is valid during T2
			if (step == ctrlPkg::stT2)
				held <= decoded;
		end
	end

	assign halted = (step == ctrlPkg::stHalted);

endmodule

//--- verif/controlUnitTb.sv
module controlUnitTb;

	localparam int period = 40;
	localparam int resetCycles = 10;
	localparam int haltCycles = 12;
	localparam int randomCount = 40;

	// Step indices of the reference model
	localparam int sReset = 0;
	localparam int sT0 = 1;
	localparam int sT1 = 2;
	localparam int sT2 = 3;
	localparam int sX1 = 4;
	localparam int sHalted = 9;

	// Opcode sweep, two branches, random run, halt, three after the second reset
	localparam int instrCount = 31 + 2 + randomCount + 1 + 3;
	// Longest instruction is 8 cycles
	localparam int timeLimit = period * (instrCount * 8 + 2 * resetCycles + haltCycles + 50);

	logic clock;
	logic reset;
	logic [isaPkg::irWidth-1:0] irReg;
	logic conff;
	ctrlPkg::controlWord_t ctrl;
	logic halted;

	// Reference state, updated on the rising edge
	isaPkg::instrClass_t expCls;
	ctrlPkg::aluOp_t expAlu;
	int expStep;
	logic expHalted;
	logic checking;
	int errors;
	int checks;

	controlUnit #(
		.irWidth(isaPkg::irWidth)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.irReg(irReg),
		.conff(conff),
		.ctrl(ctrl),
		.halted(halted)
	);

	bind controlUnit controlUnitChecks checks0 (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl),
		.halted(halted)
	);

	always #(period / 2) clock = ~clock;

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	function automatic isaPkg::instrClass_t classOf(input logic [4:0] op);
		case (op)
			5'd0: classOf = isaPkg::clsLoad;
			5'd1: classOf = isaPkg::clsLoadImm;
			5'd2: classOf = isaPkg::clsStore;
			5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11:
				classOf = isaPkg::clsAluReg;
			5'd12, 5'd13, 5'd14: classOf = isaPkg::clsAluImm;
			5'd19: classOf = isaPkg::clsBranch;
			5'd20: classOf = isaPkg::clsJumpReg;
			5'd27: classOf = isaPkg::clsHalt;
			default: classOf = isaPkg::clsNop;
		endcase
	endfunction

	function automatic ctrlPkg::aluOp_t aluOf(input logic [4:0] op);
		case (op)
			5'd0, 5'd1, 5'd2, 5'd3, 5'd12: aluOf = ctrlPkg::aluAdd;
			5'd4: aluOf = ctrlPkg::aluSub;
			5'd5: aluOf = ctrlPkg::aluShr;
			5'd6: aluOf = ctrlPkg::aluShra;
			5'd7: aluOf = ctrlPkg::aluShl;
			5'd8: aluOf = ctrlPkg::aluRor;
			5'd9: aluOf = ctrlPkg::aluRol;
			5'd10, 5'd13: aluOf = ctrlPkg::aluAnd;
			5'd11, 5'd14: aluOf = ctrlPkg::aluOr;
			5'd19: aluOf = ctrlPkg::aluBranch;
			default: aluOf = ctrlPkg::aluNone;
		endcase
	endfunction

	function automatic int stepsOf(input isaPkg::instrClass_t cls);
		case (cls)
			isaPkg::clsLoad: stepsOf = 5;
			isaPkg::clsLoadImm: stepsOf = 3;
			isaPkg::clsStore: stepsOf = 4;
			isaPkg::clsAluReg: stepsOf = 3;
			isaPkg::clsAluImm: stepsOf = 3;
			isaPkg::clsBranch: stepsOf = 4;
			default: stepsOf = 1;
		endcase
	endfunction

	function automatic ctrlPkg::controlWord_t expectedWord(
		input isaPkg::instrClass_t cls,
		input ctrlPkg::aluOp_t alu,
		input int stepIdx,
		input logic cf
	);
		ctrlPkg::controlWord_t w;
		int x;
		w = '0;
		x = stepIdx - sX1 + 1;
		case (stepIdx)
			sReset: w.clear = 1'b1;
			sT0: begin
				w.pcOut = 1'b1;
				w.marIn = 1'b1;
				w.incPc = 1'b1;
				w.zLowIn = 1'b1;
			end
			sT1: begin
				w.zLowOut = 1'b1;
				w.pcIn = 1'b1;
				w.mdRead = 1'b1;
				w.mdrIn = 1'b1;
			end
			sT2: begin
				w.mdrOut = 1'b1;
				w.irIn = 1'b1;
			end
			sHalted: ;
			default: begin
				// Execution step x of the held class
				if (x == 1 && cls inside {isaPkg::clsLoad, isaPkg::clsLoadImm,
						isaPkg::clsStore}) begin
					w.grb = 1'b1;
					w.baOut = 1'b1;
					w.yIn = 1'b1;
				end else if (x == 1 && cls inside {isaPkg::clsAluReg, isaPkg::clsAluImm}) begin
					w.grb = 1'b1;
					w.rOut = 1'b1;
					w.yIn = 1'b1;
				end else if (x == 1 && cls inside {isaPkg::clsBranch, isaPkg::clsJumpReg}) begin
					w.gra = 1'b1;
					w.rOut = 1'b1;
					w.conIn = (cls == isaPkg::clsBranch);
					w.pcIn = (cls == isaPkg::clsJumpReg);
				end else if (x == 2 && cls == isaPkg::clsAluReg) begin
					w.grc = 1'b1;
					w.rOut = 1'b1;
					w.aluOp = alu;
					w.zLowIn = 1'b1;
				end else if ((x == 2 && cls inside {isaPkg::clsLoad, isaPkg::clsLoadImm,
						isaPkg::clsStore, isaPkg::clsAluImm}) ||
						(x == 3 && cls == isaPkg::clsBranch)) begin
					w.cSignOut = 1'b1;
					w.aluOp = alu;
					w.zLowIn = 1'b1;
				end else if (x == 2 && cls == isaPkg::clsBranch) begin
					w.pcOut = 1'b1;
					w.yIn = 1'b1;
				end else if (x == 3 && cls inside {isaPkg::clsLoad, isaPkg::clsStore}) begin
					w.zLowOut = 1'b1;
					w.marIn = 1'b1;
				end else if (x == 3 && cls inside {isaPkg::clsLoadImm, isaPkg::clsAluReg,
						isaPkg::clsAluImm}) begin
					w.zLowOut = 1'b1;
					w.gra = 1'b1;
					w.rIn = 1'b1;
				end else if (x == 4 && cls == isaPkg::clsLoad) begin
					w.mdRead = 1'b1;
					w.mdrIn = 1'b1;
				end else if (x == 4 && cls == isaPkg::clsStore) begin
					w.gra = 1'b1;
					w.baOut = 1'b1;
					w.write = 1'b1;
				end else if (x == 4 && cls == isaPkg::clsBranch) begin
					w.zLowOut = 1'b1;
					w.pcIn = cf;
				end else if (x == 5 && cls == isaPkg::clsLoad) begin
					w.mdrOut = 1'b1;
					w.gra = 1'b1;
					w.rIn = 1'b1;
				end
			end
		endcase
		return w;
	endfunction

	// ------------------------------------------------------------------------
	// Compare
	// ------------------------------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s at %0t: got %h expected %h", name, $time, got, exp);
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clock) begin
		if (checking) begin
			checkValue("ctrl", ctrl, expectedWord(expCls, expAlu, expStep, conff));
			checkValue("halted", halted, expHalted);
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	task automatic driveConff(input int mode);
		if (mode < 0)
			conff <= 1'($urandom);
		else
			conff <= mode[0];
	endtask

	// Entered right after the edge into T0, left on the edge into the next T0
	task automatic runInstr(input logic [4:0] op, input int cfMode);
		isaPkg::instrClass_t cls;
		int n;
		int k;
		cls = classOf(op);
		n = stepsOf(cls);
		// IR carries noise outside T2, only the T2 sample may count
		irReg <= $urandom;
		driveConff(cfMode);
		@(posedge clock);
		expStep = sT1;
		irReg <= $urandom;
		driveConff(cfMode);
		@(posedge clock);
		expStep = sT2;
		irReg <= {op, 27'($urandom)};
		driveConff(cfMode);
		@(posedge clock);
		if (cls == isaPkg::clsHalt) begin
			expStep = sHalted;
			expHalted = 1'b1;
		end else begin
			expCls = cls;
			expAlu = aluOf(op);
			for (k = 0; k < n; k++) begin
				expStep = sX1 + k;
				irReg <= $urandom;
				driveConff(cfMode);
				@(posedge clock);
			end
			expStep = sT0;
		end
	endtask

	task automatic applyReset();
		reset <= 1'b1;
		@(posedge clock);
		expStep = sReset;
		expHalted = 1'b0;
		checking = 1'b1;
		repeat (resetCycles - 1) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		expStep = sT0;
	endtask

	initial begin
		int i;
		logic [4:0] op;
		void'($urandom(48));
		clock = 1'b0;
		reset = 1'b1;
		irReg = '0;
		conff = 1'b0;
		expCls = isaPkg::clsNop;
		expAlu = ctrlPkg::aluNone;
		expStep = sReset;
		expHalted = 1'b0;
		checking = 1'b0;
		errors = 0;
		checks = 0;

		applyReset();

		// Every opcode but halt, unlisted ones included
		for (i = 0; i < 32; i++) begin
			if (i != 27)
				runInstr(5'(i), -1);
		end

		// Branch with the condition false, then true
		runInstr(5'd19, 0);
		runInstr(5'd19, 1);

		repeat (randomCount) begin
			op = 5'($urandom);
			if (op == 5'd27)
				op = 5'd26;
			runInstr(op, -1);
		end

		// Halt must ignore the IR until reset
		runInstr(5'd27, -1);
		repeat (haltCycles) begin
			irReg <= $urandom;
			@(posedge clock);
		end

		applyReset();
		runInstr(5'd0, -1);
		runInstr(5'd3, -1);
		runInstr(5'd19, 1);

		@(negedge clock);
		#(period / 4);
		checking = 1'b0;

		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(timeLimit);
		$display("ERROR: simulation did not finish within %0d time units", timeLimit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- verif/controlUnit_assert.sv
module controlUnitChecks (
	input logic                  clock,
	input logic                  reset,
	input ctrlPkg::controlWord_t ctrl,
	input logic                  halted
);

	// ------------------------------------------------------------------------
	// Control word sanity
	// ------------------------------------------------------------------------
	regInOut: assert property (@(posedge clock) disable iff (reset)
		!(ctrl.rIn && ctrl.rOut))
		else $error("rIn and rOut high together");

	// One register select at a time
	regSelect: assert property (@(posedge clock) disable iff (reset)
		$onehot0({ctrl.gra, ctrl.grb, ctrl.grc}))
		else $error("more than one of gra, grb, grc high");

	memAccess: assert property (@(posedge clock) disable iff (reset)
		!(ctrl.mdRead && ctrl.write))
		else $error("mdRead and write high together");

	haltQuiet: assert property (@(posedge clock) disable iff (reset)
		halted |-> (ctrl == '0))
		else $error("control word not zero while halted");

endmodule
